//--- design/rob_pkg.sv
package rob_pkg;

    // two instructions dispatched and retired per cycle
    localparam int ss = 2;

    // buffer geometry
    localparam int rob_depth = 8;
    localparam int rob_id_w = 3;

    // occupancy and free counts must reach rob_depth itself
    localparam int cnt_w = 4;

    // register file indices
    localparam int arch_w = 5;
    localparam int phys_w = 6;

    // number of architectural registers held in the alias table
    localparam int arch_regs = 32;

    // retirement order number as carried by rvfi
    localparam int order_w = 64;

    // lifecycle of one buffer entry
    // free    slot holds nothing
    // issued  dispatched and waiting on the cdb
    // done    result broadcast, waiting for the head
    typedef enum logic [1:0] {
        rob_free   = 2'd0,
        rob_issued = 2'd1,
        rob_done   = 2'd2
    } rob_status_e;

    // one buffer entry
    // rd is the architectural destination
    // pd is the physical register rename picked for it
    typedef struct packed {
        rob_status_e        status;
        logic [arch_w-1:0]  rd;
        logic [phys_w-1:0]  pd;
    } rob_entry_t;

endpackage

//--- design/commit_if.sv
`timescale 1ns/1ns

// retirement bundle, one lane per superscalar slot
interface commit_if
    import rob_pkg::*;
    ();

    // lane 1 is only ever valid together with lane 0
    logic [ss-1:0]               valid;
    logic [ss-1:0][arch_w-1:0]   rd;
    logic [ss-1:0][phys_w-1:0]   pd;

    // consecutive across lanes and across cycles
    logic [ss-1:0][order_w-1:0]  order;

    // the buffer drives the bundle
    modport source (
        output valid,
        output rd,
        output pd,
        output order
    );

    // the alias table and anything else downstream only listen
    modport sink (
        input valid,
        input rd,
        input pd,
        input order
    );

endinterface

//--- design/rob_queue.sv
`timescale 1ns/1ns

module rob_queue
    import rob_pkg::*;
    (
    input  logic                       clk,
    input  logic                       rst,

    // two-wide push at the tail
    input  logic                       push,
    input  rob_entry_t [ss-1:0]        push_entry,
    // low pushes slot 0 only, high pushes both slots
    input  logic                       push_count,

    // number of entries leaving the head this cycle, 0 to 2
    input  logic [1:0]                 pop_count,

    // cdb write of the done status
    input  logic                       done_valid,
    input  logic [rob_id_w-1:0]        done_id,

    // oldest two entries, slot 0 is the head itself
    output rob_entry_t [ss-1:0]        head_entry,
    output logic [rob_id_w-1:0]        head_id,
    output logic [rob_id_w-1:0]        tail_id,
    output logic [cnt_w-1:0]           free_slots
    );

    // entry status is control state and is cleared by reset
    rob_status_e status_q [rob_depth];
    // destination payload, only meaningful while the entry is in use
    logic [arch_w-1:0] rd_q [rob_depth];
    logic [phys_w-1:0] pd_q [rob_depth];

    // pointers wrap for free since depth is a power of two
    logic [rob_id_w-1:0] head_q;
    logic [rob_id_w-1:0] tail_q;
    // occupied entries
    logic [cnt_w-1:0] count_q;

    // per-slot push enables and their total
    logic [ss-1:0] slot_push;
    logic [1:0] push_n;

    assign slot_push[0] = push;
    assign slot_push[1] = push & push_count;
    assign push_n = {1'b0, slot_push[0]} + {1'b0, slot_push[1]};

    assign head_id = head_q;
    assign tail_id = tail_q;
    assign free_slots = cnt_w'(rob_depth) - count_q;

    // read port for the commit logic
    always_comb begin
        for (int i = 0; i < ss; i++) begin
            head_entry[i].status = status_q[head_q + rob_id_w'(i)];
            head_entry[i].rd = rd_q[head_q + rob_id_w'(i)];
            head_entry[i].pd = pd_q[head_q + rob_id_w'(i)];
        end
    end

    // status and pointer update
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                status_q[i] <= rob_free;
            end
        end else begin
            // cdb only ever targets an issued entry
            if (done_valid) begin
                status_q[done_id] <= rob_done;
            end
            // retired entries go back to free
            for (int i = 0; i < ss; i++) begin
                if (pop_count > 2'(i)) begin
                    status_q[head_q + rob_id_w'(i)] <= rob_free;
                end
            end
            // tail slots are free whenever a push is allowed
            for (int i = 0; i < ss; i++) begin
                if (slot_push[i]) begin
                    status_q[tail_q + rob_id_w'(i)] <= push_entry[i].status;
                end
            end
            head_q <= head_q + rob_id_w'(pop_count);
            tail_q <= tail_q + rob_id_w'(push_n);
            count_q <= count_q + cnt_w'(push_n) - cnt_w'(pop_count);
        end
    end

    // payload written at dispatch and held until the slot is reused
    always_ff @(posedge clk) begin
        for (int i = 0; i < ss; i++) begin
            if (slot_push[i]) begin
                rd_q[tail_q + rob_id_w'(i)] <= push_entry[i].rd;
                pd_q[tail_q + rob_id_w'(i)] <= push_entry[i].pd;
            end
        end
    end

endmodule

//--- design/rob.sv
`timescale 1ns/1ns

module rob
    import rob_pkg::*;
    (
    input  logic                        clk,
    input  logic                        rst,

    // dispatch side, slot 1 only valid along with slot 0
    input  logic [ss-1:0]               dispatch_valid,
    input  logic [ss-1:0][arch_w-1:0]   dispatch_rd,
    input  logic [ss-1:0][phys_w-1:0]   dispatch_pd,
    output logic                        dispatch_ready,
    output logic [ss-1:0][rob_id_w-1:0] alloc_id,

    // common data bus
    input  logic                        cdb_valid,
    input  logic [rob_id_w-1:0]         cdb_rob_id,

    // retirement bundle towards the alias table
    commit_if.source                    commit
    );

    // queue side
    logic push;
    logic push_count;
    rob_entry_t [ss-1:0] push_entry;
    logic [1:0] pop_count;
    logic done_valid;
    rob_entry_t [ss-1:0] head_entry;
    logic [rob_id_w-1:0] head_id;
    logic [rob_id_w-1:0] tail_id;
    logic [cnt_w-1:0] free_slots;

    // distance of the cdb target from the head
    logic [rob_id_w-1:0] done_off;
    logic [cnt_w-1:0] occupied;

    // in-order commit selection
    logic [ss-1:0] commit_v;

    // retirement order counter
    logic [order_w-1:0] order_q;

    rob_queue queue0 (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .push_count (push_count),
        .pop_count  (pop_count),
        .done_valid (done_valid),
        .done_id    (cdb_rob_id),
        .head_entry (head_entry),
        .head_id    (head_id),
        .tail_id    (tail_id),
        .free_slots (free_slots)
    );

    // room for a full pair is required even when only one slot dispatches
    assign dispatch_ready = free_slots >= cnt_w'(ss);
    assign push = dispatch_ready & dispatch_valid[0];
    assign push_count = dispatch_valid[1];

    // new entries start issued and wait for the cdb
    always_comb begin
        for (int i = 0; i < ss; i++) begin
            push_entry[i].status = rob_issued;
            push_entry[i].rd = dispatch_rd[i];
            push_entry[i].pd = dispatch_pd[i];
            alloc_id[i] = tail_id + rob_id_w'(i);
        end
    end

    // drop broadcasts that fall outside the occupied window
    assign done_off = cdb_rob_id - head_id;
    assign occupied = cnt_w'(rob_depth) - free_slots;
    assign done_valid = cdb_valid & (cnt_w'(done_off) < occupied);

    // slot 1 may only retire behind slot 0
    assign commit_v[0] = head_entry[0].status == rob_done;
    assign commit_v[1] = commit_v[0] & (head_entry[1].status == rob_done);
    assign pop_count = {1'b0, commit_v[0]} + {1'b0, commit_v[1]};

    // bundle straight from the head, no register stage
    always_comb begin
        for (int i = 0; i < ss; i++) begin
            commit.valid[i] = commit_v[i];
            commit.rd[i] = head_entry[i].rd;
            commit.pd[i] = head_entry[i].pd;
            commit.order[i] = order_q + order_w'(i);
        end
    end

    // advances by however many retired this cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else begin
            order_q <= order_q + order_w'(pop_count);
        end
    end

endmodule

//--- design/rrat.sv
`timescale 1ns/1ns

module rrat
    import rob_pkg::*;
    (
    input  logic               clk,
    input  logic               rst,

    // retired instructions from the buffer
    commit_if.sink             commit,

    // read port for architectural state
    input  logic [arch_w-1:0]  query_rd,
    output logic [phys_w-1:0]  query_pd
    );

    // committed physical mapping per architectural register
    logic [phys_w-1:0] map_q [arch_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity mapping out of reset, x0 maps to p0
            for (int i = 0; i < arch_regs; i++) begin
                map_q[i] <= phys_w'(i);
            end
        end else begin
            // later slot overrides an earlier one on the same rd
            for (int i = 0; i < ss; i++) begin
                if (commit.valid[i] && (commit.rd[i] != '0)) begin
                    map_q[commit.rd[i]] <= commit.pd[i];
                end
            end
        end
    end

    // x0 is never written so it keeps reading p0
    assign query_pd = map_q[query_rd];

endmodule

//--- design/rob_top.sv
`timescale 1ns/1ns

module rob_top
    import rob_pkg::*;
    (
    input  logic                        clk,
    input  logic                        rst,

    // dispatch
    input  logic [ss-1:0]               dispatch_valid,
    input  logic [ss-1:0][arch_w-1:0]   dispatch_rd,
    input  logic [ss-1:0][phys_w-1:0]   dispatch_pd,
    output logic                        dispatch_ready,
    output logic [ss-1:0][rob_id_w-1:0] alloc_id,

    // completion
    input  logic                        cdb_valid,
    input  logic [rob_id_w-1:0]         cdb_rob_id,

    // retirement
    output logic [ss-1:0]               commit_valid,
    output logic [ss-1:0][arch_w-1:0]   commit_rd,
    output logic [ss-1:0][phys_w-1:0]   commit_pd,
    output logic [ss-1:0][order_w-1:0]  commit_order,

    // architectural mapping lookup
    input  logic [arch_w-1:0]           query_rd,
    output logic [phys_w-1:0]           query_pd
    );

    commit_if commit_bus ();

    rob rob0 (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_rd    (dispatch_rd),
        .dispatch_pd    (dispatch_pd),
        .dispatch_ready (dispatch_ready),
        .alloc_id       (alloc_id),
        .cdb_valid      (cdb_valid),
        .cdb_rob_id     (cdb_rob_id),
        .commit         (commit_bus)
    );

    rrat rrat0 (
        .clk      (clk),
        .rst      (rst),
        .commit   (commit_bus),
        .query_rd (query_rd),
        .query_pd (query_pd)
    );

    // retirement bundle also visible at the pins
    assign commit_valid = commit_bus.valid;
    assign commit_rd = commit_bus.rd;
    assign commit_pd = commit_bus.pd;
    assign commit_order = commit_bus.order;

endmodule

//--- test/rob_assert.sv
`timescale 1ns/1ns

module rob_assert
    import rob_pkg::*;
    (
    input logic                       clk,
    input logic                       rst,
    input logic                       dispatch_ready,
    input logic [rob_id_w-1:0]        tail_id,
    input logic [ss-1:0]              commit_v,
    input logic [ss-1:0][order_w-1:0] commit_order,
    input logic [order_w-1:0]         order_q
    );

    // in-order retirement, lane 1 rides behind lane 0
    slot1_behind_slot0: assert property (
        @(posedge clk) disable iff (rst) commit_v[1] |-> commit_v[0]
    ) else $error("commit slot 1 valid without slot 0");

    // full buffer ignores dispatch, so the tail holds
    no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (rst) !dispatch_ready |=> tail_id == $past(tail_id)
    ) else $error("tail advanced while dispatch_ready was low");

    // order numbers are consecutive across the two lanes
    order_pair: assert property (
        @(posedge clk) disable iff (rst)
        commit_v[1] |-> commit_order[1] == commit_order[0] + order_w'(1)
    ) else $error("slot 1 order is not slot 0 order plus one");

    // counter only grows once out of reset
    order_monotonic: assert property (
        @(posedge clk) disable iff (rst) order_q >= $past(order_q)
    ) else $error("retirement order counter went backwards");

endmodule

//--- test/tb_rob.sv
`timescale 1ns/1ns

module tb_rob
    import rob_pkg::*;
    ();

    logic clk;
    logic rst;
    logic [ss-1:0] dispatch_valid;
    logic [ss-1:0][arch_w-1:0] dispatch_rd;
    logic [ss-1:0][phys_w-1:0] dispatch_pd;
    logic dispatch_ready;
    logic [ss-1:0][rob_id_w-1:0] alloc_id;
    logic cdb_valid;
    logic [rob_id_w-1:0] cdb_rob_id;
    logic [ss-1:0] commit_valid;
    logic [ss-1:0][arch_w-1:0] commit_rd;
    logic [ss-1:0][phys_w-1:0] commit_pd;
    logic [ss-1:0][order_w-1:0] commit_order;
    logic [arch_w-1:0] query_rd;
    logic [phys_w-1:0] query_pd;

    // reference model, ids in program order plus per-id payload
    logic [rob_id_w-1:0] exp_id [$];
    logic [arch_w-1:0] exp_rd [rob_depth];
    logic [phys_w-1:0] exp_pd [rob_depth];
    logic exp_done [rob_depth];
    logic [phys_w-1:0] exp_rrat [arch_regs];
    logic [order_w-1:0] exp_order;
    logic [rob_id_w-1:0] exp_tail;
    // cdb write that lands at the coming edge
    logic pend_valid;
    logic [rob_id_w-1:0] pend_id;
    int dual_count;
    int dispatched;

    rob_top dut0 (.*);

    bind rob rob_assert rob_assert0 (
        .clk            (clk),
        .rst            (rst),
        .dispatch_ready (dispatch_ready),
        .tail_id        (tail_id),
        .commit_v       (commit_v),
        .commit_order   (commit.order),
        .order_q        (order_q)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string msg);
        report_fail($sformatf("MISMATCH at %0t ns: %s", $time, msg));
    endtask

    // retirement seen mid-cycle, popped by the dut at the next edge
    task automatic check_commits();
        logic [ss-1:0] want;
        logic [rob_id_w-1:0] id;
        want[0] = (exp_id.size() > 0) && exp_done[exp_id[0]];
        want[1] = want[0] && (exp_id.size() > 1) && exp_done[exp_id[1]];
        assert (commit_valid == want)
            else mismatch($sformatf("commit_valid %b, expected %b", commit_valid, want));
        for (int s = 0; s < ss; s++) begin
            if (commit_valid[s]) begin
                id = exp_id.pop_front();
                assert (commit_rd[s] == exp_rd[id] && commit_pd[s] == exp_pd[id])
                    else mismatch($sformatf("slot %0d retired rd %0d pd %0d, expected %0d %0d",
                        s, commit_rd[s], commit_pd[s], exp_rd[id], exp_pd[id]));
                assert (commit_order[s] == exp_order)
                    else mismatch($sformatf("slot %0d order %0d, expected %0d",
                        s, commit_order[s], exp_order));
                // x0 stays mapped to p0
                if (exp_rd[id] != '0) begin
                    exp_rrat[exp_rd[id]] = exp_pd[id];
                end
                exp_order = exp_order + order_w'(1);
            end
        end
        if (commit_valid == 2'b11) begin
            dual_count++;
        end
    endtask

    // one clock, inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(negedge clk);
        check_commits();
        @(posedge clk);
        #1;
        dispatch_valid = '0;
        cdb_valid = 1'b0;
        if (pend_valid) begin
            exp_done[pend_id] = 1'b1;
            pend_valid = 1'b0;
        end
    endtask

    task automatic complete(input logic [rob_id_w-1:0] id);
        cdb_valid = 1'b1;
        cdb_rob_id = id;
        pend_valid = 1'b1;
        pend_id = id;
    endtask

    // only entries already in the dut and not yet done
    task automatic complete_random();
        logic [rob_id_w-1:0] cand [$];
        foreach (exp_id[i]) begin
            if (!exp_done[exp_id[i]]) begin
                cand.push_back(exp_id[i]);
            end
        end
        if (cand.size() > 0) begin
            complete(cand[$urandom_range(cand.size() - 1, 0)]);
        end
    endtask

    task automatic dispatch(input int n);
        logic [rob_id_w-1:0] id;
        for (int i = 0; i < n; i++) begin
            id = exp_tail + rob_id_w'(i);
            assert (alloc_id[i] == id)
                else mismatch($sformatf("alloc_id[%0d] %0d, expected %0d", i, alloc_id[i], id));
            dispatch_valid[i] = 1'b1;
            dispatch_rd[i] = arch_w'($urandom);
            dispatch_pd[i] = phys_w'($urandom);
            exp_rd[id] = dispatch_rd[i];
            exp_pd[id] = dispatch_pd[i];
            exp_done[id] = 1'b0;
            exp_id.push_back(id);
        end
        exp_tail = exp_tail + rob_id_w'(n);
        dispatched += n;
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!dispatch_ready) begin
            if (n == limit) begin
                report_fail($sformatf("dispatch_ready stayed low for %0d cycles", limit));
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (exp_id.size() > 0) begin
            if (n == limit) begin
                report_fail($sformatf("%0d entries never retired", exp_id.size()));
            end else begin
                complete_random();
                next_cycle();
                n++;
            end
        end
    endtask

    initial begin
        int fill [5] = '{2, 1, 1, 2, 2};
        void'($urandom(77));
        rst = 1'b1;
        dispatch_valid = '0;
        dispatch_rd = '0;
        dispatch_pd = '0;
        cdb_valid = 1'b0;
        cdb_rob_id = '0;
        query_rd = '0;
        exp_order = '0;
        exp_tail = '0;
        pend_valid = 1'b0;
        pend_id = '0;
        dual_count = 0;
        dispatched = 0;
        for (int i = 0; i < arch_regs; i++) begin
            exp_rrat[i] = phys_w'(i);
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (dispatch_ready && commit_valid == '0 && commit_order[0] == '0)
            else mismatch("state after reset is not empty");
        assert (alloc_id[0] == '0 && alloc_id[1] == rob_id_w'(1))
            else mismatch("first alloc_id pair is not 0 and 1");
        // fill all eight entries with single and paired dispatches
        foreach (fill[i]) begin
            dispatch(fill[i]);
            next_cycle();
        end
        assert (!dispatch_ready) else mismatch("dispatch_ready high with a full buffer");
        // offered while full, must leave the tail alone
        dispatch_valid = '1;
        next_cycle();
        assert (alloc_id[0] == exp_tail) else mismatch("tail moved while full");
        // younger entry done first, the head blocks it
        complete(exp_id[1]);
        next_cycle();
        repeat (3) begin
            assert (commit_valid == '0) else mismatch("retired past a head that is not done");
            next_cycle();
        end
        complete(exp_id[0]);
        next_cycle();
        assert (commit_valid == 2'b11) else mismatch("done pair at the head not retired together");
        wait_ready(10);
        // ids wrap back to 0 and 1
        dispatch(2);
        next_cycle();
        repeat (400) begin
            complete_random();
            if (dispatch_ready) begin
                dispatch(int'($urandom_range(2, 0)));
            end
            next_cycle();
        end
        drain(100);
        next_cycle();
        for (int r = 0; r < arch_regs; r++) begin
            query_rd = arch_w'(r);
            #1;
            assert (query_pd == exp_rrat[r])
                else mismatch($sformatf("rrat x%0d reads p%0d, expected p%0d",
                    r, query_pd, exp_rrat[r]));
        end
        query_rd = '0;
        #1;
        assert (query_pd == '0) else mismatch("x0 no longer maps to p0");
        // empty buffer, so slot 0 shows the next order number to hand out
        assert (commit_order[0] == order_w'(dispatched))
            else mismatch($sformatf("order counter %0d after the run, expected %0d",
                commit_order[0], dispatched));
        assert (dual_count > 1) else mismatch("dual retirement never exercised");
        $display("Regression passed");
        $finish;
    end

endmodule

//--- flist.f
design/rob_pkg.sv
design/commit_if.sv
design/rob_queue.sv
design/rob.sv
design/rrat.sv
design/rob_top.sv
test/rob_assert.sv
test/tb_rob.sv

//--- run.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rob -f flist.f -o tb_rob
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_rob 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
